/* all.f */
+incdir+logic
logic/ex_pkg.sv
logic/alu_int.sv
logic/mul_unit.sv
logic/hilo_file.sv
logic/ex_stage.sv
test/ex_stage_sva.sv
test/tb_ex_stage.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_ex_stage
RTL_TOP   := ex_stage
FILELIST  := all.f
SIM_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_ex_stage.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int W = `EX_DATA_W;
    localparam int N_DIRECTED = 21;
    localparam int N_RANDOM = 200;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    aluop_e                aluop_i;
    alusel_e               alusel_i;
    logic [W-1:0]          reg1_i, reg2_i, link_address_i;
    logic [`EX_ADDR_W-1:0] wd_i, wd_o;
    logic                  wreg_i, wreg_o, whilo_o;
    logic [W-1:0]          wdata_o, hi_o, lo_o;
    logic [W-1:0]          hi_m, lo_m;
    int                    seed = 32'h1066_4077;
    int                    err_cnt = 0;
    int                    sva_fails;

    ex_stage i_ex_stage (.*);

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Result group as decode would assign it.
    function automatic alusel_e group_of(input aluop_e op);
        case (op)
            OP_OR, OP_ORI, OP_AND, OP_ANDI, OP_XOR, OP_XORI, OP_NOR: return SEL_LOGIC;
            OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV:       return SEL_SHIFT;
            OP_MFHI, OP_MFLO, OP_MOVN, OP_MOVZ:                      return SEL_MOVE;
            OP_MUL:                                                  return SEL_MUL;
            OP_JAL, OP_JALR:                                         return SEL_LINK;
            OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO:             return SEL_NOP;
            default:                                                 return SEL_ARITH;
        endcase
    endfunction

    // Presents one operation for a cycle and updates the HI/LO model.
    task automatic issue(input aluop_e op, input logic [W-1:0] a, input logic [W-1:0] b);
        aluop_i = op;
        alusel_i = group_of(op);
        reg1_i = a;
        reg2_i = b;
        link_address_i = $random(seed);
        wd_i = link_address_i[`EX_ADDR_W-1:0];
        wreg_i = (alusel_i != SEL_NOP);
        @(posedge clk);
        #2;
        case (op)
            OP_MULT:  {hi_m, lo_m} = $signed({{W{a[W-1]}}, a}) * $signed({{W{b[W-1]}}, b});
            OP_MULTU: {hi_m, lo_m} = {{W{1'b0}}, a} * {{W{1'b0}}, b};
            OP_MTHI:  hi_m = a;
            OP_MTLO:  lo_m = a;
            OP_MFHI:  check("mfhi readback", hi_m, wdata_o);
            OP_MFLO:  check("mflo readback", lo_m, wdata_o);
            default:  ;
        endcase
    endtask

    initial begin
        aluop_e op;
        int     idx;
        aluop_i = OP_NOP;
        alusel_i = SEL_NOP;
        reg1_i = '0;
        reg2_i = '0;
        wd_i = '0;
        wreg_i = 1'b0;
        link_address_i = '0;
        hi_m = '0;
        lo_m = '0;
        rst_n_i = 1'b1;
        #2;
        rst_n_i = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        issue(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        issue(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        issue(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        issue(OP_SLT, 32'hffff_ffff, 32'h0000_0001);
        issue(OP_SLTU, 32'hffff_ffff, 32'h0000_0001);
        issue(OP_SRA, 32'h0000_0004, 32'hf000_0f00);
        issue(OP_CLZ, 32'h0000_0000, '0);
        issue(OP_CLO, 32'hffff_ffff, '0);
        issue(OP_CLZ, 32'h0000_0100, '0);
        // Reads right behind a HI/LO write.
        issue(OP_MULT, 32'hffff_fffe, 32'h0000_0007);
        issue(OP_MFHI, '0, '0);
        issue(OP_MFLO, '0, '0);
        issue(OP_MTHI, 32'h1234_5678, '0);
        issue(OP_MFHI, '0, '0);
        issue(OP_MTLO, 32'h9abc_def0, '0);
        issue(OP_MFHI, '0, '0);
        issue(OP_MFLO, '0, '0);
        issue(OP_MULTU, 32'hffff_fffe, 32'h0000_0007);
        issue(OP_MUL, 32'hffff_fffd, 32'h0000_0005);
        for (int n = 0; n < N_RANDOM; n++) begin
            idx = $unsigned($random(seed)) % op.num();
            op = op.first();
            repeat (idx) op = op.next();
            issue(op, $random(seed), $random(seed));
        end
        issue(OP_NOP, '0, '0);
        issue(OP_NOP, '0, '0);
        sva_fails = i_ex_stage.i_ex_stage_sva.fail_cnt;
        $display("Errors: %0d readback, %0d assertion", err_cnt, sva_fails);
        if (err_cnt == 0 && sva_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_DIRECTED + N_RANDOM + 10 + 20) * 40);
        $display("Timeout: the operation sequence did not complete in the expected time.");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* test/ex_stage_sva.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module ex_stage_sva import ex_pkg::*; (
    input logic                  clk, rst_n_i, wreg_i, wreg_o, whilo_o,
    input aluop_e                aluop_i,
    input logic [`EX_DATA_W-1:0] reg1_i, reg2_i, link_address_i,
    input logic [`EX_ADDR_W-1:0] wd_i, wd_o,
    input logic [`EX_DATA_W-1:0] wdata_o, hi_o, lo_o
);

    localparam int W = `EX_DATA_W;

    int             fail_cnt = 0;
    logic [W:0]     ssum, sdiff;
    logic [2*W-1:0] sprod, exp_prod;
    logic [W-1:0]   exp_wdata;
    logic           trap;

    task automatic record_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endtask

    // Length of the run of b from the top bit down.
    function automatic logic [5:0] leading(input logic [W-1:0] w, input logic b);
        logic [5:0] n;
        logic       run;
        n = '0;
        run = 1'b1;
        for (int i = W - 1; i >= 0; i--) begin
            run = run && (w[i] == b);
            n = n + 6'(run);
        end
        return n;
    endfunction

    // One extra sign bit exposes signed overflow.
    assign ssum = {reg1_i[W-1], reg1_i} + {reg2_i[W-1], reg2_i};
    assign sdiff = {reg1_i[W-1], reg1_i} - {reg2_i[W-1], reg2_i};
    assign trap = (ssum[W] != ssum[W-1] && (aluop_i == OP_ADD || aluop_i == OP_ADDI)) ||
                  (sdiff[W] != sdiff[W-1] && aluop_i == OP_SUB);
    assign sprod = $signed({{W{reg1_i[W-1]}}, reg1_i}) * $signed({{W{reg2_i[W-1]}}, reg2_i});
    assign exp_prod = (aluop_i == OP_MULTU) ?
                      {{W{1'b0}}, reg1_i} * {{W{1'b0}}, reg2_i} : sprod;

    always_comb begin
        case (aluop_i)
            OP_OR, OP_ORI:     exp_wdata = reg1_i | reg2_i;
            OP_AND, OP_ANDI:   exp_wdata = reg1_i & reg2_i;
            OP_XOR, OP_XORI:   exp_wdata = reg1_i ^ reg2_i;
            OP_NOR:            exp_wdata = ~(reg1_i | reg2_i);
            OP_SLL, OP_SLLV:   exp_wdata = reg2_i << reg1_i[`EX_SHAMT_W-1:0];
            OP_SRL, OP_SRLV:   exp_wdata = reg2_i >> reg1_i[`EX_SHAMT_W-1:0];
            OP_SRA, OP_SRAV:   exp_wdata = $signed(reg2_i) >>> reg1_i[`EX_SHAMT_W-1:0];
            OP_ADD, OP_ADDI:   exp_wdata = ssum[W-1:0];
            OP_ADDU, OP_ADDIU: exp_wdata = ssum[W-1:0];
            OP_SUB, OP_SUBU:   exp_wdata = sdiff[W-1:0];
            OP_SLT, OP_SLTI:   exp_wdata = {{(W-1){1'b0}}, $signed(reg1_i) < $signed(reg2_i)};
            OP_SLTU, OP_SLTIU: exp_wdata = {{(W-1){1'b0}}, reg1_i < reg2_i};
            OP_CLZ:            exp_wdata = W'(leading(reg1_i, 1'b0));
            OP_CLO:            exp_wdata = W'(leading(reg1_i, 1'b1));
            OP_MOVN, OP_MOVZ:  exp_wdata = reg1_i;
            OP_MUL:            exp_wdata = sprod[W-1:0];
            OP_JAL, OP_JALR:   exp_wdata = link_address_i;
            default:           exp_wdata = '0;
        endcase
    end

    a_reset: assert property (@(posedge clk) !rst_n_i || !$past(rst_n_i)
        |-> !wreg_o && !whilo_o && wdata_o == '0)
        else record_failure("outputs not cleared during or right after reset");
    a_wd: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> wd_o == $past(wd_i))
        else record_failure("wd_o does not carry wd_i of the previous operation");
    a_wreg: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> wreg_o == ($past(wreg_i) && !$past(trap)))
        else record_failure("wreg_o does not follow wreg_i and the overflow rule");
    // MFHI and MFLO results depend on earlier HI/LO writes.
    a_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) && !$past(aluop_i == OP_MFHI || aluop_i == OP_MFLO)
        |-> wdata_o == $past(exp_wdata))
        else record_failure("wdata_o differs from the result of the previous operation");
    a_whilo: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> whilo_o == $past(aluop_i == OP_MULT || aluop_i == OP_MULTU ||
                                            aluop_i == OP_MTHI || aluop_i == OP_MTLO))
        else record_failure("whilo_o set on the wrong operation");
    a_prod: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(aluop_i == OP_MULT || aluop_i == OP_MULTU)
        |-> {hi_o, lo_o} == $past(exp_prod))
        else record_failure("hi_o and lo_o do not hold the 64-bit product");
    a_move_to: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(aluop_i == OP_MTHI || aluop_i == OP_MTLO)
        |-> ($past(aluop_i == OP_MTHI) ? hi_o : lo_o) == $past(reg1_i))
        else record_failure("MTHI or MTLO did not write reg1");

endmodule

bind ex_stage ex_stage_sva i_ex_stage_sva (.*);

/* logic/ex_stage.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  aluop_e                aluop_i,
    input  alusel_e               alusel_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    input  logic [`EX_ADDR_W-1:0] wd_i,
    input  logic                  wreg_i,
    input  logic [`EX_DATA_W-1:0] link_address_i,
    output logic [`EX_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output logic [`EX_DATA_W-1:0] wdata_o,
    output logic                  whilo_o,
    output logic [`EX_DATA_W-1:0] hi_o,
    output logic [`EX_DATA_W-1:0] lo_o
);

    logic [`EX_DATA_W-1:0] logic_res;
    logic [`EX_DATA_W-1:0] shift_res;
    logic [`EX_DATA_W-1:0] arith_res;
    logic [`EX_DATA_W-1:0] move_res;
    logic [`EX_DATA_W-1:0] hi_fwd;
    logic [`EX_DATA_W-1:0] lo_fwd;
    logic [`EX_DATA_W-1:0] wdata_d;
    logic                  ov;
    logic                  ov_trap;
    logic                  wreg_d;
    logic                  whilo_d;
    hilo_t                 prod;
    hilo_t                 hilo_d;
    hilo_t                 hilo_q;

    alu_int i_alu_int (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .logic_o (logic_res),
        .shift_o (shift_res),
        .arith_o (arith_res),
        .ov_o    (ov)
    );

    mul_unit i_mul_unit (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .prod_o  (prod)
    );

    hilo_file i_hilo_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (whilo_o),
        .hilo_i  (hilo_q),
        .hi_rd_o (hi_fwd),
        .lo_rd_o (lo_fwd)
    );

    always_comb begin
        case (aluop_i)
            OP_MFHI:          move_res = hi_fwd;
            OP_MFLO:          move_res = lo_fwd;
            OP_MOVN, OP_MOVZ: move_res = reg1_i;
            default:          move_res = '0;
        endcase
    end

    always_comb begin
        case (alusel_i)
            SEL_LOGIC: wdata_d = logic_res;
            SEL_SHIFT: wdata_d = shift_res;
            SEL_ARITH: wdata_d = arith_res;
            SEL_MOVE:  wdata_d = move_res;
            SEL_MUL:   wdata_d = prod.half.lo;
            SEL_LINK:  wdata_d = link_address_i;
            default:   wdata_d = '0;
        endcase
    end

    // Only the trapping adds and subtract drop the write.
    assign ov_trap = ov && ((aluop_i == OP_ADD) || (aluop_i == OP_ADDI) || (aluop_i == OP_SUB));
    assign wreg_d = wreg_i && !ov_trap;

    always_comb begin
        whilo_d = 1'b1;
        case (aluop_i)
            OP_MULT, OP_MULTU: begin
                hilo_d = prod;
            end
            OP_MTHI: begin
                hilo_d.half.hi = reg1_i;
                hilo_d.half.lo = lo_fwd;
            end
            OP_MTLO: begin
                hilo_d.half.hi = hi_fwd;
                hilo_d.half.lo = reg1_i;
            end
            default: begin
                whilo_d = 1'b0;
                hilo_d = '0;
            end
        endcase
    end

    // EX/MEM boundary.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= '0;
            whilo_o <= 1'b0;
            hilo_q  <= '0;
        end else begin
            wd_o    <= wd_i;
            wreg_o  <= wreg_d;
            wdata_o <= wdata_d;
            whilo_o <= whilo_d;
            hilo_q  <= hilo_d;
        end
    end

    assign hi_o = hilo_q.half.hi;
    assign lo_o = hilo_q.half.lo;

endmodule

/* logic/hilo_file.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module hilo_file import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  hilo_t                 hilo_i,
    output logic [`EX_DATA_W-1:0] hi_rd_o,
    output logic [`EX_DATA_W-1:0] lo_rd_o
);

    hilo_t hilo_q;
    hilo_t hilo_rd;

    // Architectural HI and LO, always written as a pair.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hilo_q <= '0;
        end else if (we_i) begin
            hilo_q <= hilo_i;
        end
    end

    // Pending write bypasses the stored pair.
    assign hilo_rd = we_i ? hilo_i : hilo_q;

    assign hi_rd_o = hilo_rd.half.hi;
    assign lo_rd_o = hilo_rd.half.lo;

endmodule

/* logic/mul_unit.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module mul_unit import ex_pkg::*; (
    input  aluop_e                aluop_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    output hilo_t                 prod_o
);

    localparam int W = `EX_DATA_W;

    logic           signed_op;
    logic           neg_res;
    logic [W-1:0]   mag1;
    logic [W-1:0]   mag2;
    logic [2*W-1:0] mag_prod;

    assign signed_op = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);

    // Sign-magnitude multiply for the signed forms.
    assign mag1 = (signed_op && reg1_i[W-1]) ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2 = (signed_op && reg2_i[W-1]) ? (~reg2_i + 1'b1) : reg2_i;
    assign mag_prod = {{W{1'b0}}, mag1} * {{W{1'b0}}, mag2};

    assign neg_res = signed_op && (reg1_i[W-1] ^ reg2_i[W-1]);

    always_comb begin
        if (neg_res) begin
            prod_o.prod = ~mag_prod + 1'b1;
        end else begin
            prod_o.prod = mag_prod;
        end
    end

endmodule

/* logic/alu_int.sv */
`timescale 1ns/1ns
`include "ex_cfg.svh"

module alu_int import ex_pkg::*; (
    input  aluop_e                aluop_i,
    input  logic [`EX_DATA_W-1:0] reg1_i,
    input  logic [`EX_DATA_W-1:0] reg2_i,
    output logic [`EX_DATA_W-1:0] logic_o,
    output logic [`EX_DATA_W-1:0] shift_o,
    output logic [`EX_DATA_W-1:0] arith_o,
    output logic                  ov_o
);

    localparam int W = `EX_DATA_W;

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   is_sub;
    logic [W-1:0]           reg2_mux;
    logic [W-1:0]           sum;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [5:0]             clz_cnt;
    logic [5:0]             clo_cnt;

    // Highest set bit wins, 32 when the word is zero.
    function automatic logic [5:0] lead_zeros(input logic [W-1:0] word);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < W; i++) begin
            if (word[i]) begin
                n = 6'(W - 1 - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        case (aluop_i)
            OP_OR, OP_ORI:   logic_o = reg1_i | reg2_i;
            OP_AND, OP_ANDI: logic_o = reg1_i & reg2_i;
            OP_XOR, OP_XORI: logic_o = reg1_i ^ reg2_i;
            OP_NOR:          logic_o = ~(reg1_i | reg2_i);
            default:         logic_o = '0;
        endcase
    end

    assign shamt = reg1_i[`EX_SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            OP_SLL, OP_SLLV: shift_o = reg2_i << shamt;
            OP_SRL, OP_SRLV: shift_o = reg2_i >> shamt;
            OP_SRA, OP_SRAV: shift_o = $unsigned($signed(reg2_i) >>> shamt);
            default:         shift_o = '0;
        endcase
    end

    // Subtract and SLT share the adder with reg2 negated.
    assign is_sub = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) ||
                    (aluop_i == OP_SLT) || (aluop_i == OP_SLTI);
    assign reg2_mux = is_sub ? (~reg2_i + 1'b1) : reg2_i;
    assign sum = reg1_i + reg2_mux;

    // Operand signs agree (after the subtract flip) but the sum sign differs.
    assign ov_o = (reg1_i[W-1] == (reg2_i[W-1] ^ is_sub)) && (sum[W-1] != reg1_i[W-1]);

    assign lt_signed = sum[W-1] ^ ov_o;
    assign lt_unsigned = reg1_i < reg2_i;

    assign clz_cnt = lead_zeros(reg1_i);
    assign clo_cnt = lead_zeros(~reg1_i);

    always_comb begin
        case (aluop_i)
            OP_SLT, OP_SLTI: begin
                arith_o = {{(W-1){1'b0}}, lt_signed};
            end
            OP_SLTU, OP_SLTIU: begin
                arith_o = {{(W-1){1'b0}}, lt_unsigned};
            end
            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU: begin
                arith_o = sum;
            end
            OP_CLZ: begin
                arith_o = {{(W-6){1'b0}}, clz_cnt};
            end
            OP_CLO: begin
                arith_o = {{(W-6){1'b0}}, clo_cnt};
            end
            default: begin
                arith_o = '0;
            end
        endcase
    end

endmodule

/* logic/ex_pkg.sv */
`include "ex_cfg.svh"

package ex_pkg;

    // Operation codes, decode-compatible encodings.
    typedef enum logic [`EX_OP_W-1:0] {
        OP_NOP   = 8'h00,
        OP_OR    = 8'h25, OP_ORI   = 8'h5A,
        OP_AND   = 8'h24, OP_ANDI  = 8'h59,
        OP_XOR   = 8'h26, OP_XORI  = 8'h5B,
        OP_NOR   = 8'h27,
        OP_SLL   = 8'h7C, OP_SLLV  = 8'h04,
        OP_SRL   = 8'h02, OP_SRLV  = 8'h06,
        OP_SRA   = 8'h03, OP_SRAV  = 8'h07,
        OP_ADD   = 8'h20, OP_ADDI  = 8'h55,
        OP_ADDU  = 8'h21, OP_ADDIU = 8'h56,
        OP_SUB   = 8'h22, OP_SUBU  = 8'h23,
        OP_SLT   = 8'h2A, OP_SLTI  = 8'h57,
        OP_SLTU  = 8'h2B, OP_SLTIU = 8'h58,
        OP_CLZ   = 8'hB0, OP_CLO   = 8'hB1,
        OP_MOVZ  = 8'h0A, OP_MOVN  = 8'h0B,
        OP_MFHI  = 8'h10, OP_MTHI  = 8'h11,
        OP_MFLO  = 8'h12, OP_MTLO  = 8'h13,
        OP_MULT  = 8'h18, OP_MULTU = 8'h19,
        OP_MUL   = 8'hA9,
        OP_JAL   = 8'h50, OP_JALR  = 8'h09
    } aluop_e;

    // Result group.
    typedef enum logic [`EX_SEL_W-1:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_MOVE  = 3'd3,
        SEL_ARITH = 3'd4,
        SEL_MUL   = 3'd5,
        SEL_LINK  = 3'd6
    } alusel_e;

    // HI/LO pair, seen as one product or as two words.
    typedef union packed {
        logic [2*`EX_DATA_W-1:0] prod;
        struct packed {
            logic [`EX_DATA_W-1:0] hi;
            logic [`EX_DATA_W-1:0] lo;
        } half;
    } hilo_t;

endpackage

/* logic/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Data path word.
`define EX_DATA_W 32

// Destination register index.
`define EX_ADDR_W 5

// Operation code from decode.
`define EX_OP_W 8

// Result group select.
`define EX_SEL_W 3

// Shift amount, low bits of reg1.
`define EX_SHAMT_W 5

`endif
